/* Bender.yml */
package:
  name: obj_video

sources:
  - src/obj_pkg.sv
  - src/obj_ifs.sv
  - src/obj_table.sv
  - src/obj_tile_match.sv
  - src/obj_scan.sv
  - src/obj_draw.sv
  - src/obj_line_buf.sv
  - src/obj_video.sv
  - target: test
    files:
      - dv/obj_ref_pkg.sv
      - dv/obj_tb.sv

/* dv/obj_ref_pkg.sv */
/*
 * obj_ref_pkg
 * testbench reference for the sprite engine: graphics ROM contents
 * and a line renderer working on a copy of the frame table
 */
`default_nettype none

package obj_ref_pkg;

    logic [15:0]       tbl_x    [1024];   // copy of every table write
    logic [15:0]       tbl_y    [1024];
    logic [15:0]       tbl_code [1024];
    logic [15:0]       tbl_attr [1024];
    obj_pkg::obj_pix_t line_exp [obj_pkg::LINE_W];   // expected line

    // fixed hash of the word address
    function automatic logic [31:0] rom_word(input logic [20:0] addr);
        logic [31:0] h;
        int          i;
        h = {11'd0, addr} * 32'h9e3779b1;
        h = h ^ (h >> 15);
        h = h * 32'h85ebca6b;
        h = h ^ (h >> 13);
        for (i = 0; i < 8; i++) begin
            if (h[4*i+2 +: 2] == 2'b11)
                h[4*i +: 4] = 4'hf;   // about a quarter see-through
        end
        return h;
    endfunction

    function automatic void render_line(input logic [8:0] vrender, input logic flip);
        logic [8:0]  vrf;
        logic [8:0]  dy;
        logic [3:0]  tm;
        logic [3:0]  tn;
        logic [3:0]  row;
        logic [3:0]  vs;
        logic [3:0]  npos;
        logic [3:0]  t;
        logic [3:0]  pc;
        logic [9:0]  ex;
        logic [15:0] cm;
        logic [63:0] tile;   // {right half, left half}
        logic        stop;
        int          e;
        int          n;
        int          k;
        int          p;
        vrf  = vrender ^ {1'b0, {8{flip}}};   // flip mirrors the low 8 bits
        stop = 1'b0;
        for (p = 0; p < obj_pkg::LINE_W; p++)
            line_exp[p] = obj_pkg::PIX_EMPTY;
        for (e = 0; e < 1024 && !stop; e++) begin
            tm = tbl_attr[e][15:12];
            tn = tbl_attr[e][11:8];
            dy = vrf - tbl_y[e][8:0];          // mod 512
            if (tbl_y[e][15] || tbl_attr[e][15:8] == 8'hff) begin
                stop = 1'b1;                   // rest of the table is dead
            end else if (int'(dy) < (int'(tm) + 1) * 16) begin
                row = tbl_attr[e][6] ? tm - dy[7:4] : dy[7:4];
                vs  = tbl_attr[e][6] ? ~dy[3:0] : dy[3:0];
                for (n = 0; n <= int'(tn); n++) begin
                    npos = tbl_attr[e][5] ? tn - n[3:0] : n[3:0];
                    ex   = tbl_x[e][9:0] + {2'd0, npos, 4'd0};
                    if (!ex[9]) begin
                        cm   = {tbl_code[e][15:8], tbl_code[e][7:4] + row,
                                tbl_code[e][3:0] + n[3:0]};
                        tile = {rom_word({cm, vs, 1'b1}), rom_word({cm, vs, 1'b0})};
                        for (k = 0; k < 16; k++) begin
                            t  = tbl_attr[e][5] ? 4'd15 - k[3:0] : k[3:0];
                            pc = tile[4*t +: 4];
                            p  = int'(ex[8:0]) + k;
                            if (pc != 4'hf && p < obj_pkg::LINE_W)
                                line_exp[p] = {tbl_x[e][15:13], tbl_attr[e][4:0], pc};
                        end
                    end
                end
            end
        end
    endfunction

endpackage

`default_nettype wire

/* dv/obj_tb.sv */
/*
 * obj_tb
 * random testbench for the sprite line engine with a ROM model of random
 * latency, a table copy and a pixel compare of every rendered line
 */
`timescale 1ns/1ns
`default_nettype none

module obj_tb;

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         tbl_we;
    logic [obj_pkg::TABLE_AW-1:0] tbl_addr;
    logic [1:0]                   tbl_sel;
    logic [15:0]                  tbl_data;
    logic                         line_start;
    logic [8:0]                   vrender;
    logic [obj_pkg::HPOS_W-1:0]   hdump;
    logic                         flip;
    logic                         rom_cs;
    logic [obj_pkg::ROM_AW-1:0]   rom_addr;
    logic [obj_pkg::ROM_DW-1:0]   rom_data = '0;
    logic                         rom_ok = 1'b0;
    int                           rom_cnt = 0;  // clocks until the ROM answers
    obj_pkg::obj_pix_t            pix;
    logic                         busy;
    int                           tests;
    int                           failed;
    int                           errors;

    always #4 clk = ~clk;

    obj_video DUT (
        .clk(clk), .rst(rst),
        .tbl_we(tbl_we), .tbl_addr(tbl_addr), .tbl_sel(tbl_sel), .tbl_data(tbl_data),
        .line_start(line_start), .vrender(vrender), .hdump(hdump), .flip(flip),
        .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_data(rom_data), .rom_ok(rom_ok),
        .pix(pix), .busy(busy)
    );

    // graphics ROM model answers 1 to 6 clocks after chip select
    always @(posedge clk) begin
        rom_ok <= 1'b0;
        if (rom_cnt > 0) begin
            rom_cnt <= rom_cnt - 1;
            if (rom_cnt == 1) begin
                rom_ok   <= 1'b1;
                rom_data <= obj_ref_pkg::rom_word(rom_addr);
            end
        end else if (rom_cs && !rom_ok) begin
            rom_cnt <= $urandom_range(6, 1);
        end
    end

    task automatic write_word(input int idx, input logic [1:0] sel, input logic [15:0] data);
        @(posedge clk);
        tbl_we   <= 1'b1;
        tbl_addr <= idx[9:0];
        tbl_sel  <= sel;
        tbl_data <= data;
    endtask

    // entry goes into the DUT and the reference copy
    task automatic write_entry(input int idx, input logic [15:0] x, y, code, attr);
        obj_ref_pkg::tbl_x[idx]    = x;
        obj_ref_pkg::tbl_y[idx]    = y;
        obj_ref_pkg::tbl_code[idx] = code;
        obj_ref_pkg::tbl_attr[idx] = attr;
        write_word(idx, 2'd0, x);
        write_word(idx, 2'd1, y);
        write_word(idx, 2'd2, code);
        write_word(idx, 2'd3, attr);
        @(posedge clk);
        tbl_we <= 1'b0;
    endtask

    task automatic add_terminator(input int idx);
        write_entry(idx, 16'd0, 16'h8000, 16'd0, 16'd0);   // y bit 15
    endtask

    // random object around the target line with some rows just off it
    task automatic add_random(input int idx, input logic [8:0] target,
                              input int xmin, input int xmax);
        logic [3:0] tm;
        logic [3:0] tn;
        int         off;
        tm  = 4'($urandom_range(15, 0));
        tn  = 4'($urandom_range(15, 0));
        off = $urandom_range((tm + 1) * 16 + 7, 0);
        write_entry(idx, {3'($urandom), 3'd0, 10'($urandom_range(xmax, xmin))},
                    {1'b0, 6'($urandom), target - 9'(off)}, 16'($urandom),
                    {tm, tn, 1'b0, 2'($urandom), 5'($urandom)});
    endtask

    task automatic load_random(input int count, input logic [8:0] target,
                               input int xmin, input int xmax);
        int i;
        for (i = 0; i < count; i++)
            add_random(i, target, xmin, xmax);
        add_terminator(count);
    endtask

    // scan and last tile row both finished
    task automatic wait_idle(input string name);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (busy && cnt < 50000) begin
            @(negedge clk);
            cnt++;
        end
        if (busy) begin
            $display("Timeout in %s: busy still high after %0d cycles", name, cnt);
            $display("STATUS: FAIL");
            $finish;
        end
    endtask

    task automatic pulse_line(input logic [8:0] vr, input logic fl);
        @(posedge clk);
        vrender    <= vr;
        flip       <= fl;
        line_start <= 1'b1;
        @(posedge clk);
        line_start <= 1'b0;
    endtask

    // render into the back bank and swap before reading it out
    task automatic run_line(input string name, input logic [8:0] vr, input logic fl);
        obj_pkg::obj_pix_t exp;
        int                bad;
        int                h;
        bad = 0;
        obj_ref_pkg::render_line(vr, fl);
        pulse_line(vr, fl);
        @(negedge clk);
        assert (busy) else begin
            $display("Error in %s: busy did not rise after line start", name);
            bad++;
        end
        wait_idle(name);
        pulse_line(vr, fl);   // rendered bank now in front
        for (h = 0; h <= obj_pkg::LINE_W; h++) begin
            @(posedge clk);
            hdump <= (h < obj_pkg::LINE_W) ? 9'(h) : 9'h1ff;   // 511 is blanking
            @(negedge clk);
            if (h > 0) begin
                exp = obj_ref_pkg::line_exp[h-1];
                assert (pix === exp) else begin
                    $display("Mismatch %s x=%0d expected %h actual %h", name, h - 1, exp, pix);
                    bad++;
                end
            end
        end
        wait_idle(name);   // scan from the second strobe done before table writes
        tests++;
        errors += bad;
        if (bad == 0) begin
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d failed checks", name, bad);
        end
    endtask

    initial begin
        logic [8:0] vr;
        int         i;
        void'($urandom(55567));
        rst        <= 1'b1;
        tbl_we     <= 1'b0;
        tbl_addr   <= '0;
        tbl_sel    <= 2'd0;
        tbl_data   <= 16'd0;
        line_start <= 1'b0;
        vrender    <= 9'd0;
        hdump      <= 9'h1ff;
        flip       <= 1'b0;
        tests  = 0;
        failed = 0;
        errors = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // one 16x16 object
        vr = 9'($urandom);
        write_entry(0, {3'($urandom), 3'd0, 10'($urandom_range(368, 0))},
                    {7'd0, vr - 9'($urandom_range(15, 0))}, 16'($urandom),
                    {8'h00, 3'b000, 5'($urandom)});
        add_terminator(1);
        run_line("single", vr, 1'b0);

        for (i = 0; i < 6; i++) begin   // multi-tile objects with random size and flips
            vr = 9'($urandom);
            load_random($urandom_range(8, 1), vr, 0, 400);
            run_line($sformatf("multi_%0d", i), vr, 1'b0);
        end

        for (i = 0; i < 3; i++) begin   // zone follows the mirrored line
            vr = 9'($urandom);
            load_random(4, vr ^ 9'h0ff, 0, 400);
            run_line($sformatf("flip_%0d", i), vr, 1'b1);
        end

        // entry 1 lands on top of entry 0 and entry 3 sits behind the terminator
        vr = 9'($urandom);
        write_entry(0, {3'd1, 3'd0, 10'd40}, {7'd0, vr}, 16'h1230, 16'h0307);
        write_entry(1, {3'd6, 3'd0, 10'd56}, {7'd0, vr - 9'd3}, 16'h4560, 16'h0321);
        add_terminator(2);
        write_entry(3, {3'd7, 3'd0, 10'd40}, {7'd0, vr}, 16'h7890, 16'h0f1f);
        run_line("overlap", vr, 1'b0);
        write_entry(1, 16'd0, 16'd0, 16'd0, 16'hff00);   // attr terminator
        write_entry(2, {3'd2, 3'd0, 10'd0}, {7'd0, vr}, 16'habcd, 16'h0f00);
        run_line("term_attr", vr, 1'b0);

        for (i = 0; i < 3; i++) begin   // right edge and x bit 9
            vr = 9'($urandom);
            load_random(6, vr, 300, 1023);
            run_line($sformatf("clip_%0d", i), vr, 1'b0);
        end

        add_terminator(0);
        run_line("clear", vr, 1'b0);
        load_random(8, vr, 0, 400);
        run_line("refill", vr, 1'b0);
        add_terminator(0);
        run_line("clear_again", vr, 1'b0);

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
src/obj_pkg.sv
src/obj_ifs.sv
src/obj_table.sv
src/obj_tile_match.sv
src/obj_scan.sv
src/obj_draw.sv
src/obj_line_buf.sv
src/obj_video.sv
dv/obj_ref_pkg.sv
dv/obj_tb.sv

/* src/obj_draw.sv */
/*
 * obj_draw
 * tile row renderer: two ROM reads per row, then 16 pixel writes
 * into the back line buffer, transparent and off-line pixels dropped
 */
`timescale 1ns/1ns
`default_nettype none

module obj_draw (
    input  wire                        clk,
    input  wire                        rst,
    obj_draw_if.slave                  dr,
    output logic                       rom_cs,
    output logic [obj_pkg::ROM_AW-1:0] rom_addr,
    input  wire  [obj_pkg::ROM_DW-1:0] rom_data,
    input  wire                        rom_ok,
    output logic                       we,
    output logic [obj_pkg::HPOS_W-1:0] waddr,
    output obj_pkg::obj_pix_t          wpix
);

    typedef enum logic [1:0] {S_IDLE, S_REQ, S_FETCH, S_WRITE} state_t;

    state_t                       st;
    logic                         half;   // 0 left 8 pixels, 1 right 8
    logic [3:0]                   k;      // screen pixel in the row
    logic [2*obj_pkg::ROM_DW-1:0] row;    // {right, left}
    logic [3:0]                   tidx;
    logic [3:0]                   color;
    logic [9:0]                   pos;

    assign rom_addr = {dr.code, dr.attr[11:8], half};
    assign dr.idle  = st == S_IDLE;
    assign tidx     = dr.attr[5] ? ~k : k;   // hflip shows 15-k
    assign color    = row[4*tidx +: 4];
    assign pos      = {1'b0, dr.hpos} + {6'd0, k};

    always_ff @(posedge clk) begin
        if (st == S_FETCH && rom_ok) begin
            if (half)
                row[2*obj_pkg::ROM_DW-1:obj_pkg::ROM_DW] <= rom_data;
            else
                row[obj_pkg::ROM_DW-1:0] <= rom_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st     <= S_IDLE;
            half   <= 1'b0;
            k      <= '0;
            rom_cs <= 1'b0;
            we     <= 1'b0;
            waddr  <= '0;
            wpix   <= obj_pkg::PIX_EMPTY;
        end else begin
            we <= 1'b0;
            case (st)
                S_IDLE: begin
                    if (dr.start) begin
                        half <= 1'b0;
                        st   <= S_REQ;
                    end
                end
                S_REQ: begin
                    rom_cs <= 1'b1;
                    st     <= S_FETCH;
                end
                S_FETCH: begin
                    if (rom_ok) begin          // cs held until the ROM answers
                        rom_cs <= 1'b0;
                        if (half) begin
                            k  <= '0;
                            st <= S_WRITE;
                        end else begin
                            half <= 1'b1;
                            st   <= S_REQ;
                        end
                    end
                end
                default: begin                 // S_WRITE, one pixel per clock
                    we    <= color != obj_pkg::TRANSP_COLOR && pos < obj_pkg::LINE_W;
                    waddr <= pos[obj_pkg::HPOS_W-1:0];
                    wpix  <= '{dr.prio, dr.attr[4:0], color};
                    k     <= k + 4'd1;
                    if (k == 4'd15)
                        st <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/obj_ifs.sv */
/*
 * sprite engine interfaces
 * obj_table_if: scanner reads one table entry per address
 * obj_draw_if: tile-row draw requests from scanner to renderer
 */
`timescale 1ns/1ns
`default_nettype none

interface obj_table_if;
    logic [obj_pkg::TABLE_AW-1:0] addr;  // entry index, data one clock later
    logic [15:0]                  x;
    logic [15:0]                  y;
    logic [15:0]                  code;
    logic [15:0]                  attr;

    modport master (output addr, input x, y, code, attr);
    modport slave  (input addr, output x, y, code, attr);
endinterface

interface obj_draw_if;
    logic                       start;  // single pulse, only while idle
    logic                       idle;
    logic [15:0]                code;   // code_mn, tile already picked
    logic [15:0]                attr;   // {4'd0, vsub, attr low byte}
    logic [obj_pkg::HPOS_W-1:0] hpos;
    logic [2:0]                 prio;

    // code/attr/hpos/prio stay put from start until idle comes back
    modport master (output start, code, attr, hpos, prio, input idle);
    modport slave  (input start, code, attr, hpos, prio, output idle);
endinterface

`default_nettype wire

/* src/obj_line_buf.sv */
/*
 * obj_line_buf
 * ping-pong line buffer: renderer fills the back bank while the
 * front bank is read out at hdump and cleared behind the beam
 */
`timescale 1ns/1ns
`default_nettype none

module obj_line_buf (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        swap,
    input  wire                        we,
    input  wire [obj_pkg::HPOS_W-1:0]  waddr,
    input  wire obj_pkg::obj_pix_t     wpix,
    input  wire [obj_pkg::HPOS_W-1:0]  hdump,
    output obj_pkg::obj_pix_t          pix
);

    obj_pkg::obj_pix_t               mem [2][obj_pkg::LINE_W];
    logic [1:0][obj_pkg::LINE_W-1:0] vld;   // location written since last read
    logic                            bank;  // front bank
    logic                            wr_ok;
    logic                            rd_ok;

    assign wr_ok = we && waddr < obj_pkg::LINE_W;
    assign rd_ok = hdump < obj_pkg::LINE_W;

    // later writes simply overwrite
    always_ff @(posedge clk) begin
        if (wr_ok)
            mem[!bank][waddr] <= wpix;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank <= 1'b0;
            vld  <= '0;   // both banks read empty
            pix  <= obj_pkg::PIX_EMPTY;
        end else begin
            if (swap)
                bank <= !bank;
            if (wr_ok)
                vld[!bank][waddr] <= 1'b1;
            if (rd_ok) begin
                pix <= vld[bank][hdump] ? mem[bank][hdump] : obj_pkg::PIX_EMPTY;
                vld[bank][hdump] <= 1'b0;   // read clears, empty for the next fill
            end else begin
                pix <= obj_pkg::PIX_EMPTY;  // blanking
            end
        end
    end

endmodule

`default_nettype wire

/* src/obj_pkg.sv */
/*
 * obj_pkg
 * constants and pixel type shared by the sprite line engine:
 * frame table size, line width, graphics ROM format
 */
`default_nettype none

package obj_pkg;

    localparam int TABLE_AW = 10;   // 1024 table entries
    localparam int LINE_W   = 384;  // visible pixels per line
    localparam int HPOS_W   = 9;
    localparam int ROM_AW   = 21;   // {code_mn, vsub, half}
    localparam int ROM_DW   = 32;   // 8 pixels of 4 bpp, nibble 0 leftmost

    localparam logic [3:0] TRANSP_COLOR = 4'd15;

    // one line buffer location
    typedef struct packed {
        logic [2:0] prio;
        logic [4:0] pal;
        logic [3:0] color;  // raw ROM nibble
    } obj_pix_t;

    localparam obj_pix_t PIX_EMPTY = '1;  // nothing drawn here

endpackage

`default_nettype wire

/* src/obj_scan.sv */
/*
 * obj_scan
 * walks the frame table once per line from entry 0, tests each object
 * against the next line and expands it into 16-pixel tile row draws
 */
`timescale 1ns/1ns
`default_nettype none

module obj_scan (
    input  wire         clk,
    input  wire         rst,
    input  wire         flip,
    input  wire  [8:0]  vrender,    // line about to be drawn
    input  wire         start,      // one pulse per line
    obj_table_if.master tbl,
    obj_draw_if.master  dr,
    output logic        done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT,     // table read in flight
        S_CHECK,    // entry valid, terminator test
        S_MATCH,    // tile_match registering
        S_ZONE,
        S_ISSUE,    // waits here on dr.idle
        S_COL,
        S_NEXT
    } state_t;

    state_t      st;
    logic [8:0]  vrenderf;
    logic [3:0]  n;         // column count
    logic [3:0]  npos;      // column screen slot, reversed with hflip
    logic [9:0]  eff_x;
    logic [3:0]  tile_m;
    logic [3:0]  tile_n;
    logic        vflip;
    logic        hflip;
    logic        term;
    logic [3:0]  vsub;
    logic        inzone;
    logic [15:0] code_mn;

    assign tile_m = tbl.attr[15:12];
    assign tile_n = tbl.attr[11:8];
    assign vflip  = tbl.attr[6];
    assign hflip  = tbl.attr[5];
    assign term   = tbl.y[15] || tbl.attr[15:8] == 8'hff;
    assign eff_x  = tbl.x[9:0] + {2'b0, npos, 4'd0};
    assign done   = st == S_IDLE;

    obj_tile_match u_match (
        .clk      (clk),
        .obj_code (tbl.code),
        .tile_m   (tile_m),
        .tile_n   (tile_n),
        .n        (n),
        .vflip    (vflip),
        .vrenderf (vrenderf),
        .obj_y    (tbl.y[8:0]),
        .vsub     (vsub),
        .inzone   (inzone),
        .code_mn  (code_mn)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= S_IDLE;
            tbl.addr <= '0;
            vrenderf <= '0;
            n        <= '0;
            npos     <= '0;
            dr.start <= 1'b0;
            dr.code  <= '0;
            dr.attr  <= '0;
            dr.hpos  <= '0;
            dr.prio  <= '0;
        end else begin
            dr.start <= 1'b0;
            case (st)
                S_IDLE: st <= S_IDLE;
                S_WAIT: st <= S_CHECK;
                S_CHECK: begin
                    n    <= 4'd0;
                    npos <= hflip ? tile_n : 4'd0;  // mirrored objects start right
                    st   <= term ? S_IDLE : S_MATCH;
                end
                S_MATCH: st <= S_ZONE;
                S_ZONE:  st <= inzone ? S_ISSUE : S_NEXT;  // skip off-line objects
                S_ISSUE: begin
                    if (eff_x[9]) begin
                        st <= S_COL;                 // clipped column, no draw
                    end else if (dr.idle) begin
                        dr.start <= 1'b1;
                        dr.code  <= code_mn;
                        dr.attr  <= {4'd0, vsub, tbl.attr[7:0]};
                        dr.hpos  <= eff_x[8:0];
                        dr.prio  <= tbl.x[15:13];
                        st       <= S_COL;
                    end
                end
                S_COL: begin
                    if (n == tile_n) begin
                        st <= S_NEXT;
                    end else begin
                        n    <= n + 4'd1;
                        npos <= hflip ? npos - 4'd1 : npos + 4'd1;
                        st   <= S_MATCH;             // new code_mn for this column
                    end
                end
                S_NEXT: begin
                    if (&tbl.addr) begin
                        st <= S_IDLE;                // past the last entry
                    end else begin
                        tbl.addr <= tbl.addr + 1'b1;
                        st       <= S_WAIT;
                    end
                end
                default: st <= S_IDLE;
            endcase
            // new line wins over whatever was going on
            if (start) begin
                st       <= S_WAIT;
                tbl.addr <= '0;
                vrenderf <= vrender ^ {1'b0, {8{flip}}};
                dr.start <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* src/obj_table.sv */
/*
 * obj_table
 * frame table RAM, 1024 entries of x/y/code/attr
 * CPU writes one word at a time, scan side reads a full entry per clock
 */
`timescale 1ns/1ns
`default_nettype none

module obj_table (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         we,
    input  wire [obj_pkg::TABLE_AW-1:0] waddr,
    input  wire [1:0]                   sel,    // 0 x, 1 y, 2 code, 3 attr
    input  wire [15:0]                  wdata,
    obj_table_if.slave                  rd
);

    localparam int DEPTH = 2 ** obj_pkg::TABLE_AW;

    logic [15:0] mem_x    [DEPTH];
    logic [15:0] mem_y    [DEPTH];
    logic [15:0] mem_code [DEPTH];
    logic [15:0] mem_attr [DEPTH];

    // CPU side
    always_ff @(posedge clk) begin
        if (we) begin
            case (sel)
                2'd0:    mem_x[waddr]    <= wdata;
                2'd1:    mem_y[waddr]    <= wdata;
                2'd2:    mem_code[waddr] <= wdata;
                default: mem_attr[waddr] <= wdata;
            endcase
        end
    end

    // scan side, all four words registered together
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd.x    <= '0;
            rd.y    <= '0;
            rd.code <= '0;
            rd.attr <= '0;
        end else begin
            rd.x    <= mem_x[rd.addr];
            rd.y    <= mem_y[rd.addr];
            rd.code <= mem_code[rd.addr];
            rd.attr <= mem_attr[rd.addr];
        end
    end

endmodule

`default_nettype wire

/* src/obj_tile_match.sv */
/*
 * obj_tile_match
 * vertical zone test for one object against the next line,
 * picks the tile row and builds the tile code for one column
 */
`timescale 1ns/1ns
`default_nettype none

module obj_tile_match (
    input  wire         clk,
    input  wire  [15:0] obj_code,
    input  wire  [3:0]  tile_m,     // extra rows
    input  wire  [3:0]  tile_n,     // extra columns
    input  wire  [3:0]  n,          // current column
    input  wire         vflip,
    input  wire  [8:0]  vrenderf,
    input  wire  [8:0]  obj_y,
    output logic [3:0]  vsub,
    output logic        inzone,
    output logic [15:0] code_mn
);

    logic [8:0] dy;
    logic [8:0] height;
    logic [3:0] m;
    logic [3:0] col;

    always_comb begin
        dy     = vrenderf - obj_y;               // wraps mod 512
        height = {1'b0, tile_m, 4'd0} + 9'd16;   // (tile_m+1)*16 lines
        m      = vflip ? tile_m - dy[7:4] : dy[7:4];
        col    = (n > tile_n) ? tile_n : n;      // column stays inside the object
    end

    always_ff @(posedge clk) begin
        inzone  <= dy < height;
        vsub    <= vflip ? ~dy[3:0] : dy[3:0];
        // nibbles wrap on their own, upper byte untouched
        code_mn <= {obj_code[15:8], obj_code[7:4] + m, obj_code[3:0] + col};
    end

endmodule

`default_nettype wire

/* src/obj_video.sv */
/*
 * obj_video
 * sprite line engine top: frame table, scanner, renderer and
 * line buffer, with the line start edge and the busy flag
 */
`timescale 1ns/1ns
`default_nettype none

module obj_video (
    input  wire                         clk,
    input  wire                         rst,
    // CPU table port
    input  wire                         tbl_we,
    input  wire [obj_pkg::TABLE_AW-1:0] tbl_addr,
    input  wire [1:0]                   tbl_sel,
    input  wire [15:0]                  tbl_data,
    // video timing
    input  wire                         line_start,
    input  wire [8:0]                   vrender,
    input  wire [obj_pkg::HPOS_W-1:0]   hdump,
    input  wire                         flip,
    // graphics ROM
    output logic                        rom_cs,
    output logic [obj_pkg::ROM_AW-1:0]  rom_addr,
    input  wire  [obj_pkg::ROM_DW-1:0]  rom_data,
    input  wire                         rom_ok,
    output obj_pkg::obj_pix_t           pix,
    output logic                        busy
);

    obj_table_if tbl_if ();
    obj_draw_if  dr_if ();

    logic                       ls_last;
    logic                       ls_rise;
    logic                       scan_done;
    logic                       buf_we;
    logic [obj_pkg::HPOS_W-1:0] buf_addr;
    obj_pkg::obj_pix_t          buf_pix;

    assign ls_rise = line_start && !ls_last;  // starts the scan and swaps banks

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ls_last <= 1'b0;
            busy    <= 1'b0;
        end else begin
            ls_last <= line_start;
            if (ls_rise)
                busy <= 1'b1;
            else if (scan_done && dr_if.idle)
                busy <= 1'b0;   // walker finished and last row written
        end
    end

    obj_table u_table (
        .clk   (clk),
        .rst   (rst),
        .we    (tbl_we),
        .waddr (tbl_addr),
        .sel   (tbl_sel),
        .wdata (tbl_data),
        .rd    (tbl_if.slave)
    );

    obj_scan u_scan (
        .clk     (clk),
        .rst     (rst),
        .flip    (flip),
        .vrender (vrender),
        .start   (ls_rise),
        .tbl     (tbl_if.master),
        .dr      (dr_if.master),
        .done    (scan_done)
    );

    obj_draw u_draw (
        .clk      (clk),
        .rst      (rst),
        .dr       (dr_if.slave),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .we       (buf_we),
        .waddr    (buf_addr),
        .wpix     (buf_pix)
    );

    obj_line_buf u_buf (
        .clk   (clk),
        .rst   (rst),
        .swap  (ls_rise),
        .we    (buf_we),
        .waddr (buf_addr),
        .wpix  (buf_pix),
        .hdump (hdump),
        .pix   (pix)
    );

endmodule

`default_nettype wire
